//--- Bender.yml
package:
  name: projector_module

sources:
  - files:
      - logic/projector_pkg.sv
      - logic/galvo_update_rate.sv
      - logic/projector_interface.sv
      - logic/dac_drive.sv
      - logic/projector_module.sv
  - target: test
    files:
      - testbench/projector_module_tb.sv

//--- logic/dac_drive.sv
`timescale 1ns/10ps
`default_nettype none

// dual 12 bit spi dac driver
// x frame, short csn gap, y frame, then ldac pulse
module dac_drive
	import projector_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  dac_req_s   dac_req,
	input  logic       req,
	output logic       ack,
	output logic       sclk,
	output logic       mosi,
	output logic       csn,
	output logic       latch,      // ldac, active low
	output logic [2:0] rgb_latched // colour shown with the latched point
);

	localparam int CNT_W = $clog2(2 * DAC_FRAME_BITS); // two clocks per bit

	localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(2 * DAC_FRAME_BITS - 1);
	localparam logic [CNT_W-1:0] LATCH_END = CNT_W'(2); // latch back high here

	typedef enum logic [2:0] {
		DRV_IDLE,  // wait for req
		DRV_GAP,   // csn high before a frame
		DRV_SHIFT, // frame on the wire
		DRV_LATCH, // settle then ldac pulse
		DRV_ACK    // ack up until req drops
	} drv_state_e;

	drv_state_e                state_q;
	logic [CNT_W-1:0]          cnt_q;  // phase within the current state
	logic                      chan_q; // set while the y frame is out
	logic [DAC_FRAME_BITS-1:0] shreg;  // msb goes out first
	logic [DAC_BITS-1:0]       y_q;
	logic [2:0]                rgb_q;

	logic capture;     // request taken
	logic gap_done;    // end of csn high time
	logic frame_start; // csn falls, first bit out
	logic bit_next;    // next bit onto mosi
	logic frame_end;   // last sclk high half done

	//////////////////////////////////////////////////////////////////////
	// phase decode
	//////////////////////////////////////////////////////////////////////

	assign capture     = (state_q == DRV_IDLE) && req && !ack;
	assign gap_done    = (cnt_q == CNT_W'(chan_q)); // 1 clk after capture, 2 between frames
	assign frame_start = (state_q == DRV_GAP) && gap_done;
	assign frame_end   = (state_q == DRV_SHIFT) && (cnt_q == BIT_LAST);
	assign bit_next    = (state_q == DRV_SHIFT) && cnt_q[0] && !frame_end;

	// frame data path
	always_ff @(posedge clk)
	begin
		if (capture)
		begin
			shreg <= {DAC_CFG_A, dac_req.x};
			y_q   <= dac_req.y;
			rgb_q <= dac_req.rgb;
		end
		else if (frame_end && !chan_q)
			shreg <= {DAC_CFG_B, y_q}; // queue the y frame
		else if (frame_start || bit_next)
			shreg <= shreg << 1;
	end

	//////////////////////////////////////////////////////////////////////
	// spi timing fsm
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state_q     <= DRV_IDLE;
			cnt_q       <= '0;
			chan_q      <= 1'b0;
			sclk        <= 1'b0;
			mosi        <= 1'b0;
			csn         <= 1'b1;
			latch       <= 1'b1;
			ack         <= 1'b0;
			rgb_latched <= 3'b000;
		end
		else
		begin
			case (state_q)
				DRV_IDLE:
				begin
					if (capture)
					begin
						chan_q  <= 1'b0; // x first
						cnt_q   <= '0;
						state_q <= DRV_GAP;
					end
				end
				DRV_GAP:
				begin
					if (gap_done)
					begin
						csn     <= 1'b0;
						mosi    <= shreg[DAC_FRAME_BITS-1];
						cnt_q   <= '0;
						state_q <= DRV_SHIFT;
					end
					else
						cnt_q <= cnt_q + 1'b1;
				end
				DRV_SHIFT:
				begin
					cnt_q <= cnt_q + 1'b1;
					sclk  <= !cnt_q[0]; // rises in second half of each bit
					if (frame_end)
					begin
						csn   <= 1'b1;
						mosi  <= 1'b0;
						cnt_q <= '0;
						if (chan_q)
							state_q <= DRV_LATCH; // both channels loaded
						else
						begin
							chan_q  <= 1'b1;
							state_q <= DRV_GAP;
						end
					end
					else if (cnt_q[0])
						mosi <= shreg[DAC_FRAME_BITS-1];
				end
				DRV_LATCH:
				begin
					cnt_q <= cnt_q + 1'b1;
					if (cnt_q == '0)
						latch <= 1'b0; // one clk after csn rises
					else if (cnt_q == LATCH_END)
					begin
						latch       <= 1'b1;
						rgb_latched <= rgb_q; // beam follows the galvo update
						ack         <= 1'b1;
						state_q     <= DRV_ACK;
					end
				end
				DRV_ACK:
				begin
					if (!req)
					begin
						ack     <= 1'b0; // last phase of handshake
						state_q <= DRV_IDLE;
					end
				end
				default:
					state_q <= DRV_IDLE;
			endcase
		end
	end

	// clock idles low outside a frame
	a_sclk_idle: assert property (@(posedge clk) disable iff (!rst_n)
		csn |-> !sclk);

	// sequencer holds req for the whole transaction
	a_req_held: assert property (@(posedge clk) disable iff (!rst_n)
		((state_q != DRV_IDLE) && !ack) |-> req);

endmodule

`default_nettype wire

//--- logic/galvo_update_rate.sv
`timescale 1ns/10ps
`default_nettype none

// programmable step strobe for the galvo sequencer
module galvo_update_rate #(
	parameter int BASE_DIV = 2700 // clocks per step at setting 0
)(
	input  logic       clk,
	input  logic       rst_n,
	input  logic [1:0] setting, // dip switch, period = BASE_DIV << setting
	output logic       strobe   // one clock wide
);

	localparam int CNT_W = $clog2(BASE_DIV * 8 + 1); // room for BASE_DIV << 3

	logic [CNT_W-1:0] period;    // current step period in clocks
	logic [CNT_W-1:0] count;     // down counter
	logic [1:0]       setting_q; // last seen setting

	assign period = CNT_W'(BASE_DIV) << setting;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			count     <= period - 1'b1;
			setting_q <= setting;
			strobe    <= 1'b0;
		end
		else if (setting != setting_q)
		begin
			// switch moved so start a fresh period
			count     <= period - 1'b1;
			setting_q <= setting;
			strobe    <= 1'b0;
		end
		else
		begin
			strobe <= (count == '0);
			if (count == '0)
				count <= period - 1'b1; // reload
			else
				count <= count - 1'b1;
		end
	end

	// sequencer expects isolated pulses
	a_strobe_single: assert property (@(posedge clk) disable iff (!rst_n)
		strobe |=> !strobe);

endmodule

`default_nettype wire

//--- logic/projector_interface.sv
`timescale 1ns/10ps
`default_nettype none

// point sequencer
// walks the two words of a physics word and hands positions to the dac
module projector_interface
	import projector_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        update,  // step strobe
	input  logic [63:0] data_in, // two projection words
	input  proj_mode_e  mode,
	output dac_req_s    dac_req, // held while req is high
	output logic        req,
	input  logic        ack
);

	typedef enum logic [1:0] {
		SEQ_IDLE, // waiting for a strobe
		SEQ_REQ,  // req up, waiting for ack
		SEQ_WAIT  // req dropped, waiting for ack low
	} seq_state_e;

	// galvo centre
	localparam logic [DAC_BITS-1:0] POS_MID = DAC_BITS'(1) << (DAC_BITS - 1);

	seq_state_e state_q;
	logic       sel_q;  // high word next when set
	proj_word_u word;   // selected half of data_in
	dac_req_s   cur_q;  // current position and colour
	dac_req_s   nxt;    // position after this word
	logic       accept; // strobe taken this cycle

	//////////////////////////////////////////////////////////////////////
	// word decode
	//////////////////////////////////////////////////////////////////////

	assign word = sel_q ? data_in[63:32] : data_in[31:0];

	always_comb
	begin
		nxt = cur_q;
		case (mode)
			MODE_ABS:
			begin
				nxt.x   = word.point.x;
				nxt.y   = word.point.y;
				nxt.rgb = word.point.rgb;
			end
			MODE_BLANK:
			begin
				nxt.x   = word.point.x;
				nxt.y   = word.point.y;
				nxt.rgb = 3'b000; // beam off while moving
			end
			MODE_REL:
			begin
				// wraps mod 4096
				nxt.x   = cur_q.x + word.step.dx;
				nxt.y   = cur_q.y + word.step.dy;
				nxt.rgb = word.step.rgb;
			end
			default:
				nxt = cur_q; // hold keeps the point
		endcase
	end

	// strobes during a transaction are dropped
	assign accept = update && (state_q == SEQ_IDLE) && !ack;

	//////////////////////////////////////////////////////////////////////
	// sequencer fsm
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state_q <= SEQ_IDLE;
			sel_q   <= 1'b0;
			cur_q   <= '{x: POS_MID, y: POS_MID, rgb: 3'b000};
			req     <= 1'b0;
		end
		else
		begin
			case (state_q)
				SEQ_IDLE:
				begin
					if (accept)
					begin
						sel_q <= !sel_q; // toggles in hold too
						if (mode != MODE_HOLD)
						begin
							cur_q   <= nxt;
							req     <= 1'b1;
							state_q <= SEQ_REQ;
						end
					end
				end
				SEQ_REQ:
				begin
					if (ack)
					begin
						req     <= 1'b0; // third phase
						state_q <= SEQ_WAIT;
					end
				end
				SEQ_WAIT:
				begin
					if (!ack)
						state_q <= SEQ_IDLE; // handshake closed
				end
				default:
					state_q <= SEQ_IDLE;
			endcase
		end
	end

	assign dac_req = cur_q;

	// payload must not move under the driver
	a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
		(req && !ack) |=> $stable(dac_req));

	// new request only once the driver let go of ack
	a_req_after_ack: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(req) |-> !ack);

endmodule

`default_nettype wire

//--- logic/projector_module.sv
`timescale 1ns/10ps
`default_nettype none

// outward facing side of the laser subsystem
// step timing, point sequencing, galvo dac and beam enable
module projector_module
	import projector_pkg::*;
#(
	parameter int BASE_DIV = 2700 // 50 us per step at 54 MHz
)(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        laser_enable, // master beam enable
	input  logic [63:0] physics_data, // two projection words
	input  logic [1:0]  update_rate,  // dip switch plot rate
	input  logic [1:0]  mode_control,
	output logic [2:0]  laser_rgb,
	output logic        dac_sclk,     // galvo dac spi
	output logic        dac_mosi,
	output logic        dac_csn,
	output logic        dac_latch
);

	logic       next_step;   // galvo step strobe
	proj_mode_e mode;
	dac_req_s   dac_req;     // point handed to the dac
	logic       req;
	logic       ack;
	logic [2:0] rgb_latched; // colour of the point on the galvos

	assign mode = proj_mode_e'(mode_control);

	//////////////////////////////////////////////////////////////////////
	// blocks
	//////////////////////////////////////////////////////////////////////

	galvo_update_rate #(
		.BASE_DIV(BASE_DIV)
	) galvo_clk (
		.clk    (clk),
		.rst_n  (rst_n),
		.setting(update_rate),
		.strobe (next_step)
	);

	projector_interface little_phazor (
		.clk    (clk),
		.rst_n  (rst_n),
		.update (next_step),
		.data_in(physics_data),
		.mode   (mode),
		.dac_req(dac_req),
		.req    (req),
		.ack    (ack)
	);

	dac_drive projector_dac (
		.clk        (clk),
		.rst_n      (rst_n),
		.dac_req    (dac_req),
		.req        (req),
		.ack        (ack),
		.sclk       (dac_sclk),
		.mosi       (dac_mosi),
		.csn        (dac_csn),
		.latch      (dac_latch),
		.rgb_latched(rgb_latched)
	);

	// beam only when enabled
	assign laser_rgb = laser_enable ? rgb_latched : 3'b000;

endmodule

`default_nettype wire

//--- logic/projector_pkg.sv
`default_nettype none

package projector_pkg;

	//////////////////////////////////////////////////////////////////////
	// galvo dac geometry
	//////////////////////////////////////////////////////////////////////

	localparam int DAC_BITS       = 12; // galvo coordinate width
	localparam int DAC_FRAME_BITS = 16; // one spi frame per channel

	// frame headers for the dual dac
	// unbuffered ref, 1x gain, output active
	localparam logic [3:0] DAC_CFG_A = 4'b0011; // channel a drives x
	localparam logic [3:0] DAC_CFG_B = 4'b1011; // channel b drives y

	//////////////////////////////////////////////////////////////////////
	// mode select from the front panel
	//////////////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		MODE_ABS   = 2'd0, // jump to absolute point
		MODE_REL   = 2'd1, // signed step from current point
		MODE_BLANK = 2'd2, // absolute move with beam off
		MODE_HOLD  = 2'd3  // park, no dac traffic
	} proj_mode_e;

	//////////////////////////////////////////////////////////////////////
	// projection word views
	//////////////////////////////////////////////////////////////////////

	// absolute view of one projection word
	typedef struct packed {
		logic [DAC_BITS-1:0] x;
		logic [DAC_BITS-1:0] y;
		logic [2:0]          rgb;   // on/off per colour
		logic [4:0]          spare;
	} proj_point_s;

	// relative view, same bit positions
	typedef struct packed {
		logic signed [DAC_BITS-1:0] dx;
		logic signed [DAC_BITS-1:0] dy;
		logic [2:0]                 rgb;
		logic [4:0]                 spare;
	} proj_step_s;

	// one 32 bit word, read as point or step depending on mode
	typedef union packed {
		proj_point_s point;
		proj_step_s  step;
	} proj_word_u;

	// payload from sequencer to dac driver
	typedef struct packed {
		logic [DAC_BITS-1:0] x;
		logic [DAC_BITS-1:0] y;
		logic [2:0]          rgb;
	} dac_req_s;

endpackage

`default_nettype wire

//--- projector_module.f
logic/projector_pkg.sv
logic/galvo_update_rate.sv
logic/projector_interface.sv
logic/dac_drive.sv
logic/projector_module.sv
testbench/projector_module_tb.sv

//--- testbench/projector_module_tb.sv
`timescale 1ns/10ps
`default_nettype none

// laser projector testbench
// table driven, one row per dac transaction or hold window
module projector_module_tb
	import projector_pkg::*;
();

	localparam int BASE_DIV = 100;
	localparam int CLK_NS   = 8;

	// one table row, inputs then expected results
	typedef struct packed {
		logic [63:0] data;
		logic [1:0]  mode;
		logic [1:0]  rate;
		logic        en;
		logic [11:0] x;          // expected galvo x
		logic [11:0] y;          // expected galvo y
		logic [2:0]  col;        // colour latched by the dac, before gating
		logic        no_txn;     // hold window, csn must stay high
		logic        chk_period; // measure csn to csn interval
	} row_s;

	logic        clk;
	logic        rst_n;
	logic        laser_enable;
	logic [63:0] physics_data;
	logic [1:0]  update_rate;
	logic [1:0]  mode_control;
	logic [2:0]  laser_rgb;
	logic        dac_sclk;
	logic        dac_mosi;
	logic        dac_csn;
	logic        dac_latch;

	row_s   rows[$];
	integer seed = 8496;
	int     n_fail;
	int     n_timeout;
	time    last_fall;  // time of previous csn fall
	logic   [2:0] shown_col; // colour on the beam after last latch

	// reference model state
	logic        sel;
	logic [11:0] pos_x;
	logic [11:0] pos_y;
	logic [2:0]  model_col;

	projector_module #(
		.BASE_DIV(BASE_DIV)
	) projector_module_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.laser_enable(laser_enable),
		.physics_data(physics_data),
		.update_rate (update_rate),
		.mode_control(mode_control),
		.laser_rgb   (laser_rgb),
		.dac_sclk    (dac_sclk),
		.dac_mosi    (dac_mosi),
		.dac_csn     (dac_csn),
		.dac_latch   (dac_latch)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = !clk;
	end

	//////////////////////////////////////////////////////////////////////
	// table construction
	//////////////////////////////////////////////////////////////////////

	// x or dx in [31:20], y or dy in [19:8], rgb in [7:5]
	function automatic logic [31:0] pack_word(input logic [11:0] a, input logic [11:0] b,
		input logic [2:0] rgb);
		pack_word = {a, b, rgb, 5'b10101}; // junk in spare bits
	endfunction

	function automatic logic [31:0] random_word();
		logic [31:0] rnd;
		logic [31:0] rgb_rnd;
		begin
			rnd       = $random(seed);
			rgb_rnd   = $random(seed);
			random_word = pack_word(rnd[11:0], rnd[23:12], rgb_rnd[2:0]);
		end
	endfunction

	task automatic add_row(input logic [63:0] data, input proj_mode_e mode,
		input logic [1:0] rate, input logic en, input logic chk);
		row_s        r;
		logic [31:0] w;
		begin
			r            = '0;
			r.data       = data;
			r.mode       = mode;
			r.rate       = rate;
			r.en         = en;
			r.chk_period = chk;
			if (mode == MODE_HOLD)
			begin
				r.no_txn = 1'b1;
				repeat (4)
					sel = !sel; // one word per strobe in the window
			end
			else
			begin
				w   = sel ? data[63:32] : data[31:0];
				sel = !sel;
				case (mode)
					MODE_REL:
					begin
						pos_x     = pos_x + w[31:20]; // 12 bit add wraps mod 4096
						pos_y     = pos_y + w[19:8];
						model_col = w[7:5];
					end
					MODE_BLANK:
					begin
						pos_x     = w[31:20];
						pos_y     = w[19:8];
						model_col = 3'b000;
					end
					default:
					begin
						pos_x     = w[31:20];
						pos_y     = w[19:8];
						model_col = w[7:5];
					end
				endcase
			end
			r.x   = pos_x;
			r.y   = pos_y;
			r.col = model_col;
			rows.push_back(r);
		end
	endtask

	task automatic build_table();
		int i;
		int rt;
		begin
			sel       = 1'b0;
			pos_x     = 12'd2048; // galvo centre after reset
			pos_y     = 12'd2048;
			model_col = 3'b000;
			// absolute, low word then high word
			add_row({pack_word(12'h5A3, 12'h0C4, 3'b011), pack_word(12'h123, 12'hABC, 3'b101)},
				MODE_ABS, 2'd0, 1'b1, 1'b0);
			add_row({pack_word(12'h5A3, 12'h0C4, 3'b011), pack_word(12'h123, 12'hABC, 3'b101)},
				MODE_ABS, 2'd0, 1'b1, 1'b0);
			// relative steps, random deltas
			for (i = 0; i < 4; i++)
				add_row({random_word(), random_word()}, MODE_REL, 2'd0, 1'b1, 1'b0);
			// forced wrap both ways
			add_row({pack_word(12'hFFF, 12'h001, 3'b100), pack_word(12'h800, 12'h7FF, 3'b001)},
				MODE_REL, 2'd0, 1'b1, 1'b0);
			add_row({pack_word(12'hFFF, 12'h001, 3'b100), pack_word(12'h800, 12'h7FF, 3'b001)},
				MODE_REL, 2'd0, 1'b1, 1'b0);
			// blanked move
			add_row({pack_word(12'h010, 12'hFE0, 3'b111), pack_word(12'h3C3, 12'h0F0, 3'b111)},
				MODE_BLANK, 2'd0, 1'b1, 1'b0);
			// beam disabled, frames still go out
			add_row({pack_word(12'h7E1, 12'h1E7, 3'b110), pack_word(12'h7E1, 12'h1E7, 3'b110)},
				MODE_ABS, 2'd0, 1'b0, 1'b0);
			add_row({pack_word(12'h222, 12'h444, 3'b010), pack_word(12'h333, 12'h555, 3'b010)},
				MODE_ABS, 2'd0, 1'b1, 1'b0);
			add_row({random_word(), random_word()}, MODE_HOLD, 2'd0, 1'b1, 1'b0);
			// plot rates, first row after a change is not timed
			for (rt = 0; rt < 4; rt++)
			begin
				add_row({random_word(), random_word()}, MODE_ABS, rt[1:0], 1'b1, 1'b0);
				add_row({random_word(), random_word()}, MODE_ABS, rt[1:0], 1'b1, 1'b1);
			end
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// row execution
	//////////////////////////////////////////////////////////////////////

	task automatic apply_row(input row_s r);
		begin
			physics_data = r.data;
			mode_control = r.mode;
			update_rate  = r.rate;
			laser_enable = r.en;
		end
	endtask

	// mode hold, csn stays high and the beam keeps its colour
	task automatic hold_window(input int idx, input row_s r);
		int n;
		begin
			for (n = 0; n < 4 * (BASE_DIV << r.rate); n++)
			begin
				@(negedge clk);
				if (dac_csn !== 1'b1)
				begin
					$display("FAIL %0t: row %0d dac_csn low in hold window", $time, idx);
					n_fail++;
				end
				if (laser_rgb !== (r.en ? shown_col : 3'b000))
				begin
					$display("FAIL %0t: row %0d laser_rgb %b changed in hold", $time, idx,
						laser_rgb);
					n_fail++;
				end
			end
		end
	endtask

	task automatic run_row(input int idx, input row_s r);
		int          cycles;
		int          nbits;
		logic [31:0] bits; // x frame then y frame
		logic        got_csn;
		logic        seen_low;
		logic        done;
		time         this_fall;
		begin
			got_csn = 1'b0;
			cycles  = 0;
			while (!got_csn && cycles < 1000)
			begin
				@(negedge clk);
				cycles++;
				if (!dac_csn)
					got_csn = 1'b1;
				else if (dac_sclk !== 1'b0 || dac_latch !== 1'b1 ||
					laser_rgb !== (r.en ? shown_col : 3'b000))
				begin
					$display("FAIL %0t: row %0d idle outputs wrong before csn", $time, idx);
					n_fail++;
				end
			end
			if (!got_csn)
			begin
				$display("row %0d: dac_csn never fell within 1000 cycles", idx);
				n_timeout++;
			end
			else
			begin
				this_fall = $time;
				if (r.chk_period && (this_fall - last_fall) != (BASE_DIV << r.rate) * CLK_NS)
				begin
					$display("FAIL %0t: row %0d csn interval %0t ns, expected %0d cycles",
						$time, idx, this_fall - last_fall, BASE_DIV << r.rate);
					n_fail++;
				end
				last_fall = this_fall;
				// collect frames until the latch pulse is over
				nbits    = 0;
				bits     = '0;
				seen_low = 1'b0;
				done     = 1'b0;
				cycles   = 0;
				while (!done && cycles < 200)
				begin
					@(negedge clk);
					cycles++;
					if (dac_sclk)
					begin
						bits = {bits[30:0], dac_mosi}; // sclk high one cycle per bit
						nbits++;
					end
					if (!dac_latch)
						seen_low = 1'b1;
					else if (seen_low)
						done = 1'b1;
				end
				if (!done)
				begin
					$display("row %0d: dac_latch pulse did not finish within 200 cycles", idx);
					n_timeout++;
				end
				else
				begin
					if (nbits != 32)
					begin
						$display("FAIL %0t: row %0d got %0d sclk bits", $time, idx, nbits);
						n_fail++;
					end
					if (bits[31:16] !== {4'b0011, r.x})
					begin
						$display("FAIL %0t: row %0d x frame %h, expected %h", $time, idx,
							bits[31:16], {4'b0011, r.x});
						n_fail++;
					end
					if (bits[15:0] !== {4'b1011, r.y})
					begin
						$display("FAIL %0t: row %0d y frame %h, expected %h", $time, idx,
							bits[15:0], {4'b1011, r.y});
						n_fail++;
					end
					if (laser_rgb !== (r.en ? r.col : 3'b000))
					begin
						$display("FAIL %0t: row %0d laser_rgb %b, expected %b", $time, idx,
							laser_rgb, r.en ? r.col : 3'b000);
						n_fail++;
					end
					shown_col = r.col;
				end
			end
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		rst_n        = 1'b0;
		laser_enable = 1'b0;
		physics_data = '0;
		update_rate  = 2'd0;
		mode_control = 2'd0;
		n_fail       = 0;
		n_timeout    = 0;
		last_fall    = 0;
		shown_col    = 3'b000;
		build_table();
		repeat (3)
			@(negedge clk);
		// outputs at rest while in reset
		if (dac_csn !== 1'b1 || dac_sclk !== 1'b0 || dac_latch !== 1'b1 || laser_rgb !== 3'b000)
		begin
			$display("FAIL %0t: reset values wrong", $time);
			n_fail++;
		end
		for (int i = 0; i < rows.size(); i++)
		begin
			apply_row(rows[i]);
			rst_n = 1'b1; // released with the first row
			if (rows[i].no_txn)
				hold_window(i, rows[i]);
			else
				run_row(i, rows[i]);
		end
		$display("errors: %0d wrong values, %0d timeouts", n_fail, n_timeout);
		if (n_fail == 0 && n_timeout == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire
